//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_axi_write_bridge
FILELIST   := build.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
OBJ_DIR    := obj_dir
PASS_MSG   := TEST PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass or fail is taken from the simulation output itself
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
+incdir+test
design/axi_bridge_pkg.sv
design/wr_txn_ctrl.sv
design/wr_channel_router.sv
design/wr_decerr_slave.sv
design/axi_write_bridge.sv
test/tb_axi_write_bridge.sv

//--- design/axi_bridge_pkg.sv
/* Shared widths, channel types and the fixed system address map
   for the single-master AXI4 write bridge */
package axi_bridge_pkg;

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int STRB_W     = DATA_W / 8;
    localparam int LEN_W      = 4;
    localparam int SIZE_W     = 3;
    localparam int MID_W      = 4;
    localparam int SID_W      = 8;
    localparam int NUM_SLAVES = 5;

    typedef logic [$clog2(NUM_SLAVES)-1:0] slave_idx_t;

    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

    // One address word, seen through either region size of the map
    typedef union packed {
        struct packed {
            logic [15:0]        region;
            logic [ADDR_W-17:0] offset;
        } r16;
        struct packed {
            logic [7:0]        region;
            logic [ADDR_W-9:0] offset;
        } r8;
    } addr_view_u;

    // Master side request, ID widened on the way to a slave
    typedef struct packed {
        logic [MID_W-1:0]  id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic [SIZE_W-1:0] size;
        logic [1:0]        burst;
    } aw_req_t;

    typedef struct packed {
        logic [SID_W-1:0]  id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic [SIZE_W-1:0] size;
        logic [1:0]        burst;
    } aw_slv_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } w_beat_t;

    typedef struct packed {
        logic [MID_W-1:0] id;
        resp_t            resp;
    } b_rsp_t;

    typedef struct packed {
        logic [SID_W-1:0] id;
        resp_t            resp;
    } b_slv_t;

    // Upper 16 bits select slaves 0 to 3
    localparam logic [15:0] REGION16_S0 = 16'h0001;
    localparam logic [15:0] REGION16_S1 = 16'h0002;
    localparam logic [15:0] REGION16_S2 = 16'h1000;
    localparam logic [15:0] REGION16_S3 = 16'h1001;

    // Slave 4 owns a whole 16 MB window
    localparam logic [7:0] REGION8_S4 = 8'h20;

endpackage

//--- design/axi_write_bridge.sv
/* AXI4 write bridge top: one master to five slaves plus a DECERR
   responder for addresses outside the map */
`timescale 1ns/1ps

module axi_write_bridge
    import axi_bridge_pkg::*;
(
    input  logic                     ACLK,
    input  logic                     ARESETn,
    input  logic                     m_aw_valid,
    input  aw_req_t                  m_aw,
    output logic                     m_aw_ready,
    input  logic                     m_w_valid,
    input  w_beat_t                  m_w,
    output logic                     m_w_ready,
    output logic                     m_b_valid,
    output b_rsp_t                   m_b,
    input  logic                     m_b_ready,
    output logic [NUM_SLAVES-1:0]    s_aw_valid,
    output aw_slv_t [NUM_SLAVES-1:0] s_aw,
    input  logic [NUM_SLAVES-1:0]    s_aw_ready,
    output logic [NUM_SLAVES-1:0]    s_w_valid,
    output w_beat_t [NUM_SLAVES-1:0] s_w,
    input  logic [NUM_SLAVES-1:0]    s_w_ready,
    input  logic [NUM_SLAVES-1:0]    s_b_valid,
    input  b_slv_t [NUM_SLAVES-1:0]  s_b,
    output logic [NUM_SLAVES-1:0]    s_b_ready
);

    logic       busy;
    logic       decerr;
    slave_idx_t sel;
    aw_req_t    aw_lat;
    logic       d_aw_valid;
    logic       d_aw_ready;
    logic       d_w_valid;
    logic       d_w_ready;
    logic       d_b_valid;
    logic       d_b_ready;
    b_rsp_t     d_b;

    wr_txn_ctrl u_ctrl (
        .ACLK     (ACLK),
        .ARESETn  (ARESETn),
        .aw_valid (m_aw_valid),
        .aw_req   (m_aw),
        .b_valid  (m_b_valid),
        .b_ready  (m_b_ready),
        .busy     (busy),
        .sel      (sel),
        .decerr   (decerr),
        .aw_lat   (aw_lat)
    );

    wr_channel_router u_router (
        .busy       (busy),
        .sel        (sel),
        .decerr     (decerr),
        .aw_lat     (aw_lat),
        .m_aw_valid (m_aw_valid),
        .m_w_valid  (m_w_valid),
        .m_w        (m_w),
        .m_b_ready  (m_b_ready),
        .m_aw_ready (m_aw_ready),
        .m_w_ready  (m_w_ready),
        .m_b_valid  (m_b_valid),
        .m_b        (m_b),
        .s_aw_valid (s_aw_valid),
        .s_aw       (s_aw),
        .s_w_valid  (s_w_valid),
        .s_w        (s_w),
        .s_b_ready  (s_b_ready),
        .s_aw_ready (s_aw_ready),
        .s_w_ready  (s_w_ready),
        .s_b_valid  (s_b_valid),
        .s_b        (s_b),
        .d_aw_valid (d_aw_valid),
        .d_w_valid  (d_w_valid),
        .d_b_ready  (d_b_ready),
        .d_aw_ready (d_aw_ready),
        .d_w_ready  (d_w_ready),
        .d_b_valid  (d_b_valid),
        .d_b        (d_b)
    );

    wr_decerr_slave u_decerr (
        .ACLK     (ACLK),
        .ARESETn  (ARESETn),
        .aw_valid (d_aw_valid),
        .aw_id    (aw_lat.id),
        .aw_ready (d_aw_ready),
        .w_valid  (d_w_valid),
        .w_last   (m_w.last),
        .w_ready  (d_w_ready),
        .b_valid  (d_b_valid),
        .b        (d_b),
        .b_ready  (d_b_ready)
    );

endmodule

//--- design/wr_channel_router.sv
/* Write channel router: steers AW and W to the selected target and
   muxes ready and the B response back to the master */
`timescale 1ns/1ps

module wr_channel_router
    import axi_bridge_pkg::*;
(
    input  logic                       busy,
    input  slave_idx_t                 sel,
    input  logic                       decerr,
    input  aw_req_t                    aw_lat,
    input  logic                       m_aw_valid,
    input  logic                       m_w_valid,
    input  w_beat_t                    m_w,
    input  logic                       m_b_ready,
    output logic                       m_aw_ready,
    output logic                       m_w_ready,
    output logic                       m_b_valid,
    output b_rsp_t                     m_b,
    output logic [NUM_SLAVES-1:0]      s_aw_valid,
    output aw_slv_t [NUM_SLAVES-1:0]   s_aw,
    output logic [NUM_SLAVES-1:0]      s_w_valid,
    output w_beat_t [NUM_SLAVES-1:0]   s_w,
    output logic [NUM_SLAVES-1:0]      s_b_ready,
    input  logic [NUM_SLAVES-1:0]      s_aw_ready,
    input  logic [NUM_SLAVES-1:0]      s_w_ready,
    input  logic [NUM_SLAVES-1:0]      s_b_valid,
    input  b_slv_t [NUM_SLAVES-1:0]    s_b,
    output logic                       d_aw_valid,
    output logic                       d_w_valid,
    output logic                       d_b_ready,
    input  logic                       d_aw_ready,
    input  logic                       d_w_ready,
    input  logic                       d_b_valid,
    input  b_rsp_t                     d_b
);

    logic    to_slave;
    logic    to_decerr;
    aw_slv_t aw_wide;

    assign to_slave  = busy && !decerr;
    assign to_decerr = busy && decerr;

    // Zero-extend the master ID to slave width
    assign aw_wide = '{
        id:    {{(SID_W - MID_W){1'b0}}, aw_lat.id},
        addr:  aw_lat.addr,
        len:   aw_lat.len,
        size:  aw_lat.size,
        burst: aw_lat.burst
    };

    // Forward path, all unselected targets held at zero
    always_comb begin
        for (int i = 0; i < NUM_SLAVES; i++) begin
            if (to_slave && (sel == slave_idx_t'(i))) begin
                s_aw_valid[i] = m_aw_valid;
                s_aw[i]       = aw_wide;
                s_w_valid[i]  = m_w_valid;
                s_w[i]        = m_w;
                s_b_ready[i]  = m_b_ready;
            end else begin
                s_aw_valid[i] = 1'b0;
                s_aw[i]       = '0;
                s_w_valid[i]  = 1'b0;
                s_w[i]        = '0;
                s_b_ready[i]  = 1'b0;
            end
        end
        d_aw_valid = to_decerr && m_aw_valid;
        d_w_valid  = to_decerr && m_w_valid;
        d_b_ready  = to_decerr && m_b_ready;
    end

    // Return path
    always_comb begin
        m_aw_ready = 1'b0;
        m_w_ready  = 1'b0;
        m_b_valid  = 1'b0;
        m_b        = '0;
        if (to_decerr) begin
            m_aw_ready = d_aw_ready;
            m_w_ready  = d_w_ready;
            m_b_valid  = d_b_valid;
            m_b        = d_b;
        end else if (to_slave) begin
            m_aw_ready = s_aw_ready[sel];
            m_w_ready  = s_w_ready[sel];
            m_b_valid  = s_b_valid[sel];
            m_b.id     = s_b[sel].id[MID_W-1:0];
            m_b.resp   = s_b[sel].resp;
        end
    end

    always_comb begin
        a_one_target: assert ($onehot0({d_aw_valid, s_aw_valid}))
            else $error("aw_valid driven to more than one target");
    end

endmodule

//--- design/wr_decerr_slave.sv
/* Default responder for unmapped addresses: accepts the whole burst
   and answers DECERR with the master's ID */
`timescale 1ns/1ps

module wr_decerr_slave
    import axi_bridge_pkg::*;
(
    input  logic             ACLK,
    input  logic             ARESETn,
    input  logic             aw_valid,
    input  logic [MID_W-1:0] aw_id,
    output logic             aw_ready,
    input  logic             w_valid,
    input  logic             w_last,
    output logic             w_ready,
    output logic             b_valid,
    output b_rsp_t           b,
    input  logic             b_ready
);

    typedef enum logic [1:0] {
        PH_ADDR = 2'd0,
        PH_DATA = 2'd1,
        PH_RESP = 2'd2
    } phase_t;

    phase_t           phase;
    logic [MID_W-1:0] id_lat;

    assign aw_ready = (phase == PH_ADDR);
    assign w_ready  = (phase == PH_DATA);
    assign b_valid  = (phase == PH_RESP);
    assign b        = '{id: id_lat, resp: RESP_DECERR};

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            phase <= PH_ADDR;
        end else begin
            case (phase)
                PH_ADDR: if (aw_valid) phase <= PH_DATA;
                // No beat count, last closes the burst
                PH_DATA: if (w_valid && w_last) phase <= PH_RESP;
                PH_RESP: if (b_ready) phase <= PH_ADDR;
                default: phase <= PH_ADDR;
            endcase
        end
    end

    always_ff @(posedge ACLK) begin
        if (aw_valid && aw_ready) begin
            id_lat <= aw_id;
        end
    end

    a_b_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        b_valid && !b_ready |=> b_valid && $stable(b))
        else $error("DECERR response dropped before b_ready");

endmodule

//--- design/wr_txn_ctrl.sv
/* Write transaction controller: FREE/DATA state machine that decodes
   the address and holds the request until the master B transfer */
`timescale 1ns/1ps

module wr_txn_ctrl
    import axi_bridge_pkg::*;
(
    input  logic       ACLK,
    input  logic       ARESETn,
    input  logic       aw_valid,
    input  aw_req_t    aw_req,
    input  logic       b_valid,
    input  logic       b_ready,
    output logic       busy,
    output slave_idx_t sel,
    output logic       decerr,
    output aw_req_t    aw_lat
);

    typedef enum logic {
        FREE = 1'b0,
        DATA = 1'b1
    } state_t;

    state_t     state;
    addr_view_u addr_view;
    slave_idx_t dec_sel;
    logic       dec_miss;
    logic       start;

    assign addr_view = aw_req.addr;
    assign start     = (state == FREE) && aw_valid;
    assign busy      = (state == DATA);

    // Address map decode
    always_comb begin
        dec_sel  = '0;
        dec_miss = 1'b0;
        if (addr_view.r16.region == REGION16_S0) begin
            dec_sel = slave_idx_t'(0);
        end else if (addr_view.r16.region == REGION16_S1) begin
            dec_sel = slave_idx_t'(1);
        end else if (addr_view.r16.region == REGION16_S2) begin
            dec_sel = slave_idx_t'(2);
        end else if (addr_view.r16.region == REGION16_S3) begin
            dec_sel = slave_idx_t'(3);
        end else if (addr_view.r8.region == REGION8_S4) begin
            dec_sel = slave_idx_t'(4);
        end else begin
            dec_miss = 1'b1;
        end
    end

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            state  <= FREE;
            sel    <= '0;
            decerr <= 1'b0;
        end else if (start) begin
            state  <= DATA;
            sel    <= dec_sel;
            decerr <= dec_miss;
        end else if (busy && b_valid && b_ready) begin
            state <= FREE;
        end
    end

    always_ff @(posedge ACLK) begin
        if (start) begin
            aw_lat <= aw_req;
        end
    end

    // Routing must not move under an open burst
    a_sel_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
        $past(busy) && busy |-> $stable(sel) && $stable(decerr))
        else $error("target changed during a write");

endmodule

//--- test/tb_bridge_checks.svh
/* Testbench helpers for the write bridge: LFSR stimulus source,
   reference address routing and typed compare tasks */
`ifndef TB_BRIDGE_CHECKS_SVH
`define TB_BRIDGE_CHECKS_SVH

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

// Roughly 1 in 4 when stalling hard, 1 in 2 otherwise
function automatic bit ready_draw();
    if (heavy_stall) begin
        return take_bits(2) == 0;
    end
    return take_bits(1) != 0;
endfunction

// Slave index for an address, -1 when outside the map
function automatic int expected_target(input logic [ADDR_W-1:0] addr);
    if (addr[31:16] == 16'h0001) return 0;
    if (addr[31:16] == 16'h0002) return 1;
    if (addr[31:16] == 16'h1000) return 2;
    if (addr[31:16] == 16'h1001) return 3;
    if (addr[31:24] == 8'h20) return 4;
    return -1;
endfunction

task automatic compare_aw(input string name, input aw_slv_t got, input aw_slv_t exp,
                          inout int errs);
    if (got !== exp) begin
        $display("[FAIL] %s got %h expected %h", name, got, exp);
        errs++;
    end
endtask

task automatic compare_w(input string name, input w_beat_t got, input w_beat_t exp,
                         inout int errs);
    if (got !== exp) begin
        $display("[FAIL] %s got %h expected %h", name, got, exp);
        errs++;
    end
endtask

task automatic compare_b(input string name, input b_rsp_t got, input b_rsp_t exp,
                         inout int errs);
    if (got !== exp) begin
        $display("[FAIL] %s got %h expected %h", name, got, exp);
        errs++;
    end
endtask

task automatic compare_flags(input string name, input logic [3*NUM_SLAVES+2:0] got,
                             input logic [3*NUM_SLAVES+2:0] exp, inout int errs);
    if (got !== exp) begin
        $display("[FAIL] %s got %h expected %h", name, got, exp);
        errs++;
    end
endtask

`endif

//--- test/tb_axi_write_bridge.sv
/* Testbench for the AXI4 write bridge: random-ready slave models,
   master stimulus and a monitor that checks every transfer */
`timescale 1ns/1ps

module tb_axi_write_bridge
    import axi_bridge_pkg::*;
;

    localparam int N_WRITES   = 5 + 2 + 8 + 40;
    // 16 beats at most per write, 40 cycles per beat, plus reset
    localparam int MAX_CYCLES = N_WRITES * 16 * 40 + 10;

    logic                     ACLK       = 1'b0;
    logic                     ARESETn    = 1'b0;
    logic                     m_aw_valid = 1'b0;
    aw_req_t                  m_aw       = '0;
    logic                     m_aw_ready;
    logic                     m_w_valid  = 1'b0;
    w_beat_t                  m_w        = '0;
    logic                     m_w_ready;
    logic                     m_b_valid;
    b_rsp_t                   m_b;
    logic                     m_b_ready  = 1'b0;
    logic [NUM_SLAVES-1:0]    s_aw_valid;
    aw_slv_t [NUM_SLAVES-1:0] s_aw;
    logic [NUM_SLAVES-1:0]    s_aw_ready = '0;
    logic [NUM_SLAVES-1:0]    s_w_valid;
    w_beat_t [NUM_SLAVES-1:0] s_w;
    logic [NUM_SLAVES-1:0]    s_w_ready  = '0;
    logic [NUM_SLAVES-1:0]    s_b_valid  = '0;
    b_slv_t [NUM_SLAVES-1:0]  s_b        = '0;
    logic [NUM_SLAVES-1:0]    s_b_ready;

    logic [31:0]      lfsr_state  = 32'h97e3_e427;
    bit               heavy_stall = 1'b0;
    int               mon_errs    = 0;
    int               run_errs    = 0;
    int               tests_run   = 0;
    int               tests_ok    = 0;
    int               stray_cycles = 0;
    int               open_writes = 0;
    int               cycles      = 0;
    int               exp_slave   = -1;
    aw_slv_t          exp_aw_q[$];
    w_beat_t          exp_w_q[$];
    b_rsp_t           exp_b_q[$];
    bit [NUM_SLAVES-1:0] aw_seen   = '0;
    bit [NUM_SLAVES-1:0] last_seen = '0;
    bit [NUM_SLAVES-1:0] b_pend    = '0;
    logic [SID_W-1:0] slv_id [NUM_SLAVES] = '{default: '0};

    `include "tb_bridge_checks.svh"

    axi_write_bridge u_dut (
        .ACLK       (ACLK),
        .ARESETn    (ARESETn),
        .m_aw_valid (m_aw_valid),
        .m_aw       (m_aw),
        .m_aw_ready (m_aw_ready),
        .m_w_valid  (m_w_valid),
        .m_w        (m_w),
        .m_w_ready  (m_w_ready),
        .m_b_valid  (m_b_valid),
        .m_b        (m_b),
        .m_b_ready  (m_b_ready),
        .s_aw_valid (s_aw_valid),
        .s_aw       (s_aw),
        .s_aw_ready (s_aw_ready),
        .s_w_valid  (s_w_valid),
        .s_w        (s_w),
        .s_w_ready  (s_w_ready),
        .s_b_valid  (s_b_valid),
        .s_b        (s_b),
        .s_b_ready  (s_b_ready)
    );

    // 8 ns period
    always #4 ACLK = ~ACLK;

    always @(posedge ACLK) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Slave models, state taken at the rising edge
    always @(posedge ACLK) begin
        for (int i = 0; i < NUM_SLAVES; i++) begin
            if (!ARESETn) begin
                aw_seen[i]   = 1'b0;
                last_seen[i] = 1'b0;
                b_pend[i]    = 1'b0;
            end else begin
                if (s_aw_valid[i] && s_aw_ready[i]) begin
                    slv_id[i]  = s_aw[i].id;
                    aw_seen[i] = 1'b1;
                end
                if (s_w_valid[i] && s_w_ready[i] && s_w[i].last) begin
                    last_seen[i] = 1'b1;
                end
                if (s_b_valid[i] && s_b_ready[i]) begin
                    b_pend[i] = 1'b0;
                end
                if (aw_seen[i] && last_seen[i]) begin
                    b_pend[i]    = 1'b1;
                    aw_seen[i]   = 1'b0;
                    last_seen[i] = 1'b0;
                end
            end
        end
    end

    // Slave and master-side outputs change on the falling edge
    always @(negedge ACLK) begin
        for (int i = 0; i < NUM_SLAVES; i++) begin
            s_aw_ready[i] = ready_draw();
            s_w_ready[i]  = ready_draw();
            s_b_valid[i]  = b_pend[i];
            s_b[i]        = '{id: slv_id[i], resp: RESP_OKAY};
        end
        m_b_ready = ready_draw();
    end

    // Compares every transfer against what the stimulus expects
    always @(posedge ACLK) begin
        if (ARESETn) begin
            for (int i = 0; i < NUM_SLAVES; i++) begin
                if ((s_aw_valid[i] || s_w_valid[i]) && i != exp_slave) begin
                    stray_cycles++;
                end
                if (s_aw_valid[i] && s_aw_ready[i]) begin
                    if (exp_aw_q.size() == 0) begin
                        $display("unexpected write address at slave %0d", i);
                        mon_errs++;
                    end else begin
                        compare_aw($sformatf("s_aw[%0d]", i), s_aw[i], exp_aw_q.pop_front(),
                                   mon_errs);
                    end
                end
                if (s_w_valid[i] && s_w_ready[i]) begin
                    if (exp_w_q.size() == 0) begin
                        $display("extra write beat at slave %0d", i);
                        mon_errs++;
                    end else begin
                        compare_w($sformatf("s_w[%0d]", i), s_w[i], exp_w_q.pop_front(),
                                  mon_errs);
                    end
                end
            end
            if (m_aw_valid && m_aw_ready) begin
                open_writes++;
            end
            if (m_b_valid && m_b_ready) begin
                // Each response closes exactly one accepted address
                if (open_writes != 1) begin
                    $display("write response after %0d accepted write addresses",
                             open_writes);
                    mon_errs++;
                end
                open_writes = 0;
                if (exp_b_q.size() == 0) begin
                    $display("write response with no write outstanding");
                    mon_errs++;
                end else begin
                    compare_b("m_b", m_b, exp_b_q.pop_front(), mon_errs);
                end
            end
        end
    end

    function automatic logic [ADDR_W-1:0] region_addr(input int r);
        case (r)
            0: return {16'h0001, 16'(take_bits(16))};
            1: return {16'h0002, 16'(take_bits(16))};
            2: return {16'h1000, 16'(take_bits(16))};
            3: return {16'h1001, 16'(take_bits(16))};
            default: return {8'h20, 24'(take_bits(24))};
        endcase
    endfunction

    // Upper byte 40 to 7f lies outside every region
    function automatic logic [ADDR_W-1:0] unmapped_addr();
        return {2'b01, 30'(take_bits(30))};
    endfunction

    function automatic logic [ADDR_W-1:0] random_addr();
        int pick;
        pick = int'(take_bits(3));
        if (pick < NUM_SLAVES) begin
            return region_addr(pick);
        end
        return unmapped_addr();
    endfunction

    function automatic aw_req_t make_req(input logic [ADDR_W-1:0] addr);
        aw_req_t req;
        req.id    = MID_W'(take_bits(MID_W));
        req.addr  = addr;
        req.len   = LEN_W'(take_bits(LEN_W));
        req.size  = 3'd2;
        req.burst = 2'b01;
        return req;
    endfunction

    task automatic run_write(input aw_req_t req);
        int      target;
        int      beats;
        aw_slv_t exp_aw;
        b_rsp_t  exp_b;
        w_beat_t beat;
        w_beat_t beat_q[$];
        target = expected_target(req.addr);
        beats  = int'(req.len) + 1;
        for (int k = 0; k < beats; k++) begin
            beat.data = DATA_W'(take_bits(DATA_W));
            beat.strb = STRB_W'(take_bits(STRB_W));
            beat.last = (k == beats - 1);
            beat_q.push_back(beat);
            if (target >= 0) begin
                exp_w_q.push_back(beat);
            end
        end
        exp_aw.id    = SID_W'(req.id);
        exp_aw.addr  = req.addr;
        exp_aw.len   = req.len;
        exp_aw.size  = req.size;
        exp_aw.burst = req.burst;
        if (target >= 0) begin
            exp_aw_q.push_back(exp_aw);
        end
        exp_b.id   = req.id;
        exp_b.resp = (target >= 0) ? RESP_OKAY : RESP_DECERR;
        exp_b_q.push_back(exp_b);
        exp_slave = target;
        fork
            begin
                @(negedge ACLK);
                m_aw_valid = 1'b1;
                m_aw       = req;
                do begin
                    @(posedge ACLK);
                end while (!m_aw_ready);
                @(negedge ACLK);
                m_aw_valid = 1'b0;
            end
            begin
                foreach (beat_q[k]) begin
                    @(negedge ACLK);
                    m_w_valid = 1'b1;
                    m_w       = beat_q[k];
                    do begin
                        @(posedge ACLK);
                    end while (!m_w_ready);
                end
                @(negedge ACLK);
                m_w_valid = 1'b0;
            end
        join
        do begin
            @(posedge ACLK);
        end while (!(m_b_valid && m_b_ready));
        @(negedge ACLK);
    endtask

    task automatic finish_test(input string name, input int base_errs, input int base_stray);
        int errs;
        if (exp_aw_q.size() != 0 || exp_w_q.size() != 0 || exp_b_q.size() != 0) begin
            $display("%s: %0d address, %0d data, %0d response transfers never arrived",
                     name, exp_aw_q.size(), exp_w_q.size(), exp_b_q.size());
            run_errs++;
            exp_aw_q.delete();
            exp_w_q.delete();
            exp_b_q.delete();
        end
        if (stray_cycles != base_stray) begin
            $display("%s: a slave other than the target saw a valid", name);
            run_errs++;
        end
        errs = mon_errs + run_errs - base_errs;
        tests_run++;
        if (errs == 0) begin
            tests_ok++;
            $display("[ ok ] %s", name);
        end else begin
            $display("[bad ] %s with %0d errors", name, errs);
        end
    endtask

    initial begin
        int base_errs;
        int base_stray;
        repeat (10) @(posedge ACLK);
        @(negedge ACLK);
        ARESETn = 1'b1;
        @(negedge ACLK);

        base_errs  = mon_errs + run_errs;
        base_stray = stray_cycles;
        compare_flags("idle outputs", {m_aw_ready, m_w_ready, m_b_valid, s_aw_valid,
                      s_w_valid, s_b_ready}, '0, run_errs);
        finish_test("reset_idle", base_errs, base_stray);

        base_errs  = mon_errs + run_errs;
        base_stray = stray_cycles;
        for (int r = 0; r < NUM_SLAVES; r++) begin
            run_write(make_req(region_addr(r)));
        end
        finish_test("route_regions", base_errs, base_stray);

        base_errs  = mon_errs + run_errs;
        base_stray = stray_cycles;
        run_write(make_req({16'h0003, 16'(take_bits(16))}));
        run_write(make_req(unmapped_addr()));
        finish_test("unmapped_decerr", base_errs, base_stray);

        base_errs   = mon_errs + run_errs;
        base_stray  = stray_cycles;
        heavy_stall = 1'b1;
        for (int n = 0; n < 8; n++) begin
            run_write(make_req(random_addr()));
        end
        heavy_stall = 1'b0;
        finish_test("stall_back_to_back", base_errs, base_stray);

        base_errs  = mon_errs + run_errs;
        base_stray = stray_cycles;
        for (int n = 0; n < 40; n++) begin
            run_write(make_req(random_addr()));
        end
        finish_test("random_mix", base_errs, base_stray);

        $display("%0d tests, %0d clean, %0d errors", tests_run, tests_ok,
                 mon_errs + run_errs);
        if (mon_errs + run_errs == 0 && tests_ok == tests_run) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
